//--- hw/ooo_pkg.sv
package ooo_pkg;

    // Core sizes
    localparam int xlen        = 32;
    localparam int rob_entries = 8;
    localparam int rs_entries  = 4;
    localparam int reg_count   = 32;
    localparam int rob_tag_w   = $clog2(rob_entries);
    localparam int rs_idx_w    = $clog2(rs_entries);
    localparam int reg_id_w    = $clog2(reg_count);

    // Supported RV32I major opcodes
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_lui = 7'b0110111;

    typedef logic [rob_tag_w-1:0] rob_tag_t;
    typedef logic [reg_id_w-1:0]  reg_id_t;
    typedef logic [xlen-1:0]      word_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass
    } alu_op_t;

    // Value when valid, otherwise the tag of the producer
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

    typedef struct packed {
        alu_op_t  op;
        operand_t src1;
        operand_t src2;
        rob_tag_t dest;
    } rs_entry_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    typedef struct packed {
        reg_id_t rd;
    } rob_alloc_t;

    typedef struct packed {
        logic    busy;
        logic    ready;
        reg_id_t rd;
        word_t   value;
    } rob_entry_t;

    typedef rob_entry_t [rob_entries-1:0] rob_view_t;

    typedef struct packed {
        logic     valid;
        reg_id_t  rd;
        rob_tag_t tag;
        word_t    value;
    } commit_t;

endpackage : ooo_pkg

//--- hw/dispatch_unit.sv
`timescale 1ns/10ps

module dispatch_unit
    import ooo_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  word_t      wb_dat_i,
    output logic       wb_ack_o,
    output logic       wb_err_o,
    output reg_id_t    rs1_o,
    output reg_id_t    rs2_o,
    input  operand_t   src1_i,
    input  operand_t   src2_i,
    output logic       rename_o,
    output reg_id_t    rename_rd_o,
    output rob_tag_t   rename_tag_o,
    output logic       rob_write_o,
    output rob_alloc_t rob_alloc_o,
    input  rob_tag_t   rob_free_tag_i,
    input  logic       rob_full_i,
    input  rob_view_t  rob_view_i,
    output logic       rs_write_o,
    output rs_entry_t  rs_entry_o,
    input  logic       rs_full_i,
    input  cdb_t       cdb_i
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_id_t    rd;
    word_t      imm_i;
    word_t      imm_u;
    logic       supported;
    logic       req;
    logic       accept;
    logic       refuse;
    logic       ack_q;
    logic       err_q;
    alu_op_t    op;

    // Finish a pending operand from a ready ROB entry or the live CDB
    function automatic operand_t resolve(operand_t src, rob_view_t view, cdb_t cdb);
        operand_t res;
        res = src;
        if (!src.valid) begin
            if (view[src.tag].ready) begin
                res.valid = 1'b1;
                res.value = view[src.tag].value;
            end else if (cdb.valid && cdb.tag == src.tag) begin
                res.valid = 1'b1;
                res.value = cdb.value;
            end
        end
        return res;
    endfunction

    assign opcode = wb_dat_i[6:0];
    assign rd     = wb_dat_i[11:7];
    assign funct3 = wb_dat_i[14:12];
    assign imm_i  = {{(xlen-12){wb_dat_i[31]}}, wb_dat_i[31:20]};
    assign imm_u  = {wb_dat_i[31:12], 12'b0};

    // LUI reads x0 so its first operand is a ready zero
    assign rs1_o = (opcode == op_lui) ? '0 : wb_dat_i[19:15];
    assign rs2_o = wb_dat_i[24:20];

    // Reads on the instruction port are refused as well
    assign supported = wb_we_i && (opcode inside {op_reg, op_imm, op_lui});
    assign req       = wb_cyc_i && wb_stb_i && !ack_q && !err_q;
    assign accept    = req && supported && !rs_full_i && !rob_full_i;
    assign refuse    = req && !supported;

    always_comb begin
        op = alu_add;
        if (opcode == op_lui) begin
            op = alu_pass;
        end else begin
            case (funct3)
                3'd0: op = (opcode == op_reg && wb_dat_i[30]) ? alu_sub : alu_add;
                3'd1: op = alu_sll;
                3'd2: op = alu_slt;
                3'd3: op = alu_sltu;
                3'd4: op = alu_xor;
                3'd5: op = wb_dat_i[30] ? alu_sra : alu_srl;
                3'd6: op = alu_or;
                default: op = alu_and;
            endcase
        end
    end

    always_comb begin
        rs_entry_o.op   = op;
        rs_entry_o.dest = rob_free_tag_i;
        rs_entry_o.src1 = resolve(src1_i, rob_view_i, cdb_i);
        if (opcode == op_reg) begin
            rs_entry_o.src2 = resolve(src2_i, rob_view_i, cdb_i);
        end else begin
            rs_entry_o.src2.valid = 1'b1;
            rs_entry_o.src2.tag   = '0;
            rs_entry_o.src2.value = (opcode == op_lui) ? imm_u : imm_i;
        end
    end

    assign rs_write_o     = accept;
    assign rob_write_o    = accept;
    assign rob_alloc_o.rd = rd;
    assign rename_o       = accept && (rd != '0);
    assign rename_rd_o    = rd;
    assign rename_tag_o   = rob_free_tag_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= accept;
            err_q <= refuse;
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_err_o = err_q;

    ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(wb_ack_o && wb_err_o));

endmodule : dispatch_unit

//--- hw/reg_file.sv
`timescale 1ns/10ps

module reg_file
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_id_t  rs1_i,
    input  reg_id_t  rs2_i,
    output operand_t src1_o,
    output operand_t src2_o,
    input  logic     rename_i,
    input  reg_id_t  rename_rd_i,
    input  rob_tag_t rename_tag_i,
    input  commit_t  commit_i
);

    word_t                regs_q [reg_count];
    logic [reg_count-1:0] busy_q;
    rob_tag_t             tag_q [reg_count];

    // Pending registers return their producer tag instead of a value
    function automatic operand_t read_port(reg_id_t r);
        operand_t res;
        res.valid = 1'b1;
        res.tag   = '0;
        res.value = '0;
        if (r != '0) begin
            res.valid = !busy_q[r];
            res.tag   = tag_q[r];
            res.value = regs_q[r];
        end
        return res;
    endfunction

    assign src1_o = read_port(rs1_i);
    assign src2_o = read_port(rs2_i);

    // Architectural values follow program order through commit
    always_ff @(posedge clk) begin
        if (commit_i.valid && commit_i.rd != '0) begin
            regs_q[commit_i.rd] <= commit_i.value;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
            for (int r = 0; r < reg_count; r++) begin
                tag_q[r] <= '0;
            end
        end else begin
            // Only the latest producer releases the register
            if (commit_i.valid && commit_i.rd != '0 && tag_q[commit_i.rd] == commit_i.tag) begin
                busy_q[commit_i.rd] <= 1'b0;
            end
            // Same-cycle rename overrides the release above
            if (rename_i && rename_rd_i != '0) begin
                busy_q[rename_rd_i] <= 1'b1;
                tag_q[rename_rd_i]  <= rename_tag_i;
            end
        end
    end

    no_x0_rename: assert property (@(posedge clk) disable iff (!rst_n_i)
        rename_i |-> rename_rd_i != '0);

endmodule : reg_file

//--- hw/alu_rs.sv
`timescale 1ns/10ps

module alu_rs
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      write_i,
    input  rs_entry_t entry_i,
    output logic      full_o,
    input  cdb_t      cdb_i,
    output cdb_t      cdb_o
);

    rs_entry_t             slot_q [rs_entries];
    logic [rs_entries-1:0] valid_q;
    logic [rs_idx_w-1:0]   age_q [rs_entries];   // Count of younger entries held
    logic [rs_entries-1:0] ready;
    logic [rs_idx_w-1:0]   free_idx;
    logic [rs_idx_w-1:0]   issue_idx;
    logic                  issue_vld;
    logic                  cdb_vld_q;
    rob_tag_t              cdb_tag_q;
    word_t                 cdb_val_q;

    function automatic word_t alu(alu_op_t op, word_t a, word_t b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: return {{(xlen-1){1'b0}}, a < b};
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return word_t'($signed(a) >>> b[4:0]);
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return b;
        endcase
    endfunction

    assign full_o = &valid_q;

    always_comb begin
        free_idx  = '0;
        issue_vld = 1'b0;
        issue_idx = '0;
        for (int i = rs_entries - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = rs_idx_w'(i);
            end
        end
        for (int i = 0; i < rs_entries; i++) begin
            ready[i] = valid_q[i] && slot_q[i].src1.valid && slot_q[i].src2.valid;
            if (ready[i] && (!issue_vld || age_q[i] > age_q[issue_idx])) begin
                issue_vld = 1'b1;
                issue_idx = rs_idx_w'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q   <= '0;
            cdb_vld_q <= 1'b0;
            for (int i = 0; i < rs_entries; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            cdb_vld_q <= issue_vld;
            // Ages stay distinct: grow on a write, shrink when a younger one leaves
            for (int i = 0; i < rs_entries; i++) begin
                if (valid_q[i]) begin
                    age_q[i] <= age_q[i] + rs_idx_w'(write_i)
                              - rs_idx_w'(issue_vld && age_q[i] > age_q[issue_idx]);
                end
            end
            if (issue_vld) begin
                valid_q[issue_idx] <= 1'b0;
            end
            if (write_i) begin
                valid_q[free_idx] <= 1'b1;
                age_q[free_idx]   <= '0;
            end
        end
    end

    // Wakeup, allocation and result capture
    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_entries; i++) begin
            if (valid_q[i] && cdb_i.valid) begin
                if (!slot_q[i].src1.valid && slot_q[i].src1.tag == cdb_i.tag) begin
                    slot_q[i].src1.valid <= 1'b1;
                    slot_q[i].src1.value <= cdb_i.value;
                end
                if (!slot_q[i].src2.valid && slot_q[i].src2.tag == cdb_i.tag) begin
                    slot_q[i].src2.valid <= 1'b1;
                    slot_q[i].src2.value <= cdb_i.value;
                end
            end
        end
        if (write_i) begin
            slot_q[free_idx] <= entry_i;
        end
        cdb_tag_q <= slot_q[issue_idx].dest;
        cdb_val_q <= alu(slot_q[issue_idx].op, slot_q[issue_idx].src1.value,
                         slot_q[issue_idx].src2.value);
    end

    assign cdb_o.valid = cdb_vld_q;
    assign cdb_o.tag   = cdb_tag_q;
    assign cdb_o.value = cdb_val_q;

    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        write_i |-> !full_o);

endmodule : alu_rs

//--- hw/ro_buffer.sv
`timescale 1ns/10ps

module ro_buffer
    import ooo_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       write_i,
    input  rob_alloc_t alloc_i,
    output rob_tag_t   free_tag_o,
    output logic       full_o,
    output rob_view_t  view_o,
    input  cdb_t       cdb_i,
    output commit_t    commit_o,
    output logic       cm_cyc_o,
    output logic       cm_stb_o,
    output logic       cm_we_o,
    output reg_id_t    cm_adr_o,
    output word_t      cm_dat_o,
    input  logic       cm_ack_i
);

    logic [rob_entries-1:0] busy_q;
    logic [rob_entries-1:0] ready_q;
    reg_id_t                rd_q [rob_entries];
    word_t                  value_q [rob_entries];
    rob_tag_t               head_q;
    rob_tag_t               tail_q;
    logic                   cm_stb_q;
    logic                   retire;

    // Entries free in order, so a busy tail means every slot is taken
    assign free_tag_o = tail_q;
    assign full_o     = busy_q[tail_q];
    assign retire     = cm_stb_q && cm_ack_i;

    always_comb begin
        for (int i = 0; i < rob_entries; i++) begin
            view_o[i].busy  = busy_q[i];
            view_o[i].ready = ready_q[i];
            view_o[i].rd    = rd_q[i];
            view_o[i].value = value_q[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q   <= '0;
            ready_q  <= '0;
            head_q   <= '0;
            tail_q   <= '0;
            cm_stb_q <= 1'b0;
        end else begin
            if (cdb_i.valid) begin
                ready_q[cdb_i.tag] <= 1'b1;
            end
            if (write_i) begin
                busy_q[tail_q]  <= 1'b1;
                ready_q[tail_q] <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            // One Wishbone write per retired entry
            if (cm_stb_q) begin
                if (cm_ack_i) begin
                    cm_stb_q        <= 1'b0;
                    busy_q[head_q]  <= 1'b0;
                    ready_q[head_q] <= 1'b0;
                    head_q          <= head_q + 1'b1;
                end
            end else if (busy_q[head_q] && ready_q[head_q]) begin
                cm_stb_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_i) begin
            rd_q[tail_q] <= alloc_i.rd;
        end
        if (cdb_i.valid) begin
            value_q[cdb_i.tag] <= cdb_i.value;
        end
    end

    // Head payload is stable for the whole bus cycle
    assign cm_cyc_o = cm_stb_q;
    assign cm_stb_o = cm_stb_q;
    assign cm_we_o  = cm_stb_q;
    assign cm_adr_o = rd_q[head_q];
    assign cm_dat_o = value_q[head_q];

    assign commit_o.valid = retire;
    assign commit_o.rd    = rd_q[head_q];
    assign commit_o.tag   = head_q;
    assign commit_o.value = value_q[head_q];

    cdb_hits_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb_i.valid |-> busy_q[cdb_i.tag]);

endmodule : ro_buffer

//--- hw/ooo_core.sv
`timescale 1ns/10ps

module ooo_core
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,

    // Instruction port, Wishbone slave
    input  logic    wb_cyc_i,
    input  logic    wb_stb_i,
    input  logic    wb_we_i,
    input  word_t   wb_dat_i,
    output logic    wb_ack_o,
    output logic    wb_err_o,

    // Commit port, Wishbone master
    output logic    cm_cyc_o,
    output logic    cm_stb_o,
    output logic    cm_we_o,
    output reg_id_t cm_adr_o,
    output word_t   cm_dat_o,
    input  logic    cm_ack_i
);

    reg_id_t    rs1, rs2;
    operand_t   src1, src2;
    logic       rename;
    reg_id_t    rename_rd;
    rob_tag_t   rename_tag;
    logic       rob_write;
    rob_alloc_t rob_alloc;
    rob_tag_t   rob_free_tag;
    logic       rob_full;
    rob_view_t  rob_view;
    logic       rs_write;
    rs_entry_t  rs_entry;
    logic       rs_full;
    cdb_t       cdb;        // Driven by alu_rs only
    commit_t    commit;

    dispatch_unit dispatch_unit_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i),
        .wb_dat_i(wb_dat_i),
        .wb_ack_o(wb_ack_o),
        .wb_err_o(wb_err_o),
        // Operand lookup and rename
        .rs1_o(rs1),
        .rs2_o(rs2),
        .src1_i(src1),
        .src2_i(src2),
        .rename_o(rename),
        .rename_rd_o(rename_rd),
        .rename_tag_o(rename_tag),
        // Allocation
        .rob_write_o(rob_write),
        .rob_alloc_o(rob_alloc),
        .rob_free_tag_i(rob_free_tag),
        .rob_full_i(rob_full),
        .rob_view_i(rob_view),
        .rs_write_o(rs_write),
        .rs_entry_o(rs_entry),
        .rs_full_i(rs_full),
        .cdb_i(cdb)
    );

    reg_file reg_file_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .rs1_i(rs1),
        .rs2_i(rs2),
        .src1_o(src1),
        .src2_o(src2),
        .rename_i(rename),
        .rename_rd_i(rename_rd),
        .rename_tag_i(rename_tag),
        .commit_i(commit)
    );

    alu_rs alu_rs_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .write_i(rs_write),
        .entry_i(rs_entry),
        .full_o(rs_full),
        .cdb_i(cdb),
        .cdb_o(cdb)
    );

    ro_buffer ro_buffer_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .write_i(rob_write),
        .alloc_i(rob_alloc),
        .free_tag_o(rob_free_tag),
        .full_o(rob_full),
        .view_o(rob_view),
        .cdb_i(cdb),
        .commit_o(commit),
        .cm_cyc_o(cm_cyc_o),
        .cm_stb_o(cm_stb_o),
        .cm_we_o(cm_we_o),
        .cm_adr_o(cm_adr_o),
        .cm_dat_o(cm_dat_o),
        .cm_ack_i(cm_ack_i)
    );

endmodule : ooo_core

//--- verification/tb_ooo_core.sv
`timescale 1ns/10ps

module tb_ooo_core
    import ooo_pkg::*;
();

    localparam int wait_limit = 200;

    logic    clk = 1'b0;
    logic    rst_n_i;
    logic    wb_cyc_i;
    logic    wb_stb_i;
    logic    wb_we_i;
    word_t   wb_dat_i;
    logic    wb_ack_o;
    logic    wb_err_o;
    logic    cm_cyc_o;
    logic    cm_stb_o;
    logic    cm_we_o;
    reg_id_t cm_adr_o;
    word_t   cm_dat_o;
    logic    cm_ack_i;

    // Trace contents, split by the process that consumes them
    word_t   stim_word [$];
    logic    stim_refused [$];
    reg_id_t exp_rd [$];
    word_t   exp_value [$];

    int      mismatch_count = 0;
    int      failure_count  = 0;
    logic    aborted        = 1'b0;

    ooo_core ooo_core_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i),
        .wb_dat_i(wb_dat_i),
        .wb_ack_o(wb_ack_o),
        .wb_err_o(wb_err_o),
        .cm_cyc_o(cm_cyc_o),
        .cm_stb_o(cm_stb_o),
        .cm_we_o(cm_we_o),
        .cm_adr_o(cm_adr_o),
        .cm_dat_o(cm_dat_o),
        .cm_ack_i(cm_ack_i)
    );

    always #5 clk = ~clk;

    task automatic load_trace();
        int            fd;
        int            code;
        byte           kind;
        word_t         word;
        int            rd;
        logic [1023:0] skip_buf;
        fd = $fopen("verification/ooo_core_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file");
            failure_count++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "#") begin
                code = $fgets(skip_buf, fd);
            end else if (kind == "I" || kind == "E") begin
                code = $fscanf(fd, "%h", word);
                stim_word.push_back(word);
                stim_refused.push_back(kind == "E");
            end else if (kind == "C") begin
                code = $fscanf(fd, "%d %h", rd, word);
                exp_rd.push_back(reg_id_t'(rd));
                exp_value.push_back(word);
            end else begin
                $display("The trace file holds a line of unknown kind %c", kind);
                failure_count++;
                break;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_idle(string phase);
        if (wb_ack_o !== 1'b0 || wb_err_o !== 1'b0 ||
            cm_cyc_o !== 1'b0 || cm_stb_o !== 1'b0) begin
            $display("MISMATCH at %0t: bus outputs not idle %s", $time, phase);
            mismatch_count++;
        end
    endtask

    // Back to back writes, the next word goes out on the answering edge
    task automatic drive_instructions();
        int   waited;
        logic seen;
        for (int i = 0; i < stim_word.size() && !aborted; i++) begin
            wb_cyc_i <= 1'b1;
            wb_stb_i <= 1'b1;
            wb_we_i  <= 1'b1;
            wb_dat_i <= stim_word[i];
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < wait_limit) begin
                @(posedge clk);
                if (wb_ack_o || wb_err_o) begin
                    seen = 1'b1;
                end else begin
                    waited++;
                end
            end
            if (!seen) begin
                $display("Timed out waiting for an answer to instruction word %h",
                         stim_word[i]);
                failure_count++;
                aborted = 1'b1;
            end else if (wb_err_o !== stim_refused[i] || wb_ack_o === stim_refused[i]) begin
                $display("MISMATCH at %0t: word %h got ack=%b err=%b, expected err=%b",
                         $time, stim_word[i], wb_ack_o, wb_err_o, stim_refused[i]);
                mismatch_count++;
            end
        end
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic respond_commits();
        int   waited;
        int   delay;
        logic seen;
        for (int n = 0; n < exp_rd.size() && !aborted; n++) begin
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < wait_limit) begin
                @(posedge clk);
                if (cm_stb_o) begin
                    seen = 1'b1;
                end else begin
                    waited++;
                end
            end
            if (!seen) begin
                $display("Timed out waiting for commit number %0d", n);
                failure_count++;
                aborted = 1'b1;
            end else begin
                if (cm_adr_o !== exp_rd[n] || cm_dat_o !== exp_value[n] ||
                    cm_cyc_o !== 1'b1 || cm_we_o !== 1'b1) begin
                    $display("MISMATCH at %0t: commit %0d wrote x%0d=%h, expected x%0d=%h",
                             $time, n, cm_adr_o, cm_dat_o, exp_rd[n], exp_value[n]);
                    mismatch_count++;
                end
                // Slow acks let the reorder buffer fill up
                delay = $urandom % 5;
                repeat (delay) @(posedge clk);
                if (cm_stb_o !== 1'b1) begin
                    $display("MISMATCH at %0t: commit strobe dropped before ack", $time);
                    mismatch_count++;
                end
                cm_ack_i <= 1'b1;
                @(posedge clk);
                cm_ack_i <= 1'b0;
            end
        end
    endtask

    initial begin : main_seq
        logic extra_seen;
        extra_seen = 1'b0;
        void'($urandom(32'h1fc0_7440));
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_dat_i = '0;
        cm_ack_i = 1'b0;
        load_trace();

        // First edge clears the flops, later ones can be checked
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            if (c > 0) begin
                check_idle("during reset");
            end
        end
        rst_n_i <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            check_idle("after reset");
        end

        fork
            drive_instructions();
            respond_commits();
        join

        // Refused words and repeats would show up as extra commits
        repeat (20) begin
            @(posedge clk);
            if (cm_stb_o && !extra_seen) begin
                $display("A commit appeared after the last expected one");
                failure_count++;
                extra_seen = 1'b1;
            end
        end

        $display("Mismatches: %0d, other errors: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_ooo_core

//--- vlog.f
hw/ooo_pkg.sv
hw/dispatch_unit.sv
hw/reg_file.sv
hw/alu_rs.sv
hw/ro_buffer.sv
hw/ooo_core.sv
verification/tb_ooo_core.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  # Shared package first, then the blocks, then the top level
  - files:
      - hw/ooo_pkg.sv
      - hw/dispatch_unit.sv
      - hw/reg_file.sv
      - hw/alu_rs.sv
      - hw/ro_buffer.sv
      - hw/ooo_core.sv

  - target: test
    files:
      - verification/tb_ooo_core.sv

//--- verification/ooo_core_trace.txt
# I <word hex> = accepted instruction, E <word hex> = refused word
# C <rd decimal> <value hex> = expected commit, in program order
I 123450B7
C 1 12345000
I 06400113
C 2 00000064
I FF900193
C 3 FFFFFFF9
# Operands through the CDB and a ready buffer entry
I 00310233
C 4 0000005D
I 403102B3
C 5 0000006B
E 00012303
I 0020C333
C 6 12345064
I 00411393
C 7 00000640
I 4011D413
C 8 FFFFFFFC
I 01C1D493
C 9 0000000F
I 0021A533
C 10 00000001
I 0021B5B3
C 11 00000000
# Write to x0, then x0 read as zero
I 00510013
C 0 00000069
I 00100613
C 12 00000001
# x14 renamed twice before it commits
I 00110713
C 14 00000065
I 00170713
C 14 00000066
I 004707B3
C 15 000000C3
E 00000063
I 0070E833
C 16 12345640
I 003878B3
C 17 12345640
I 00961933
C 18 00008000
I 40C45A33
C 20 FFFFFFFE
I 0FF14B93
C 23 0000009B
# x1 and x2 long retired, read from the register file
I 00208CB3
C 25 12345064
E 00001297
